/* list.f */
source/core_pkg.sv
source/mem_cmd_if.sv
source/core_control.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu_unit.sv
source/mem_port.sv
source/rv_multicycle_top.sv
verification/core_props.sv
verification/tb_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_core -o sim_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

/* verification/tb_core.sv */
`timescale 1ns/100ps

module tb_core;

    localparam int halt_addr = 32'h3fc;
    localparam int res_base  = 128;  // Result area at byte 0x200.

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic mem_valid, mem_write, mem_ready = 1'b1;
    logic [31:0] mem_addr, mem_wdata, mem_rdata = '0;

    logic [31:0] mem [256];
    logic [31:0] lfsr = 32'hd26a;
    logic [31:0] alu_first [16];
    logic [31:0] alu_exp [16];
    logic [31:0] first_addr, first_wr_addr;
    logic stall_en = 1'b0;
    logic halt_seen, seen_first, seen_write, first_write;
    int pi, test_errors, tests_run, tests_failed;

    rv_multicycle_top #(.reset_pc(32'h0), .reg_count(32)) dut0 (
        .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // Memory responds a little after the edge; one LFSR bit per ready decision.
    always @(posedge clk) begin
        #2;
        if (stall_en) begin
            mem_ready = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end else begin
            mem_ready = 1'b1;
        end
        mem_rdata = mem[mem_addr[9:2]];
    end

    always @(negedge clk) begin
        if (!reset && mem_valid && mem_ready) begin
            if (!seen_first) begin
                seen_first  = 1'b1;
                first_addr  = mem_addr;
                first_write = mem_write;
            end
            if (mem_write) begin
                if (!seen_write) first_wr_addr = mem_addr;
                seen_write = 1'b1;
                mem[mem_addr[9:2]] = mem_wdata;
                if (mem_addr == halt_addr) halt_seen = 1'b1;
            end
        end
    end

    task automatic emit(input logic [31:0] w);
        mem[pi] = w;
        pi++;
    endtask

    task automatic begin_test();
        @(posedge clk);
        #2 reset = 1'b1;
        for (int i = 0; i < 256; i++) mem[i] = 32'h5a000000 ^ (i * 32'h00010101);
        pi = 0;
        test_errors = 0;
        {halt_seen, seen_first, seen_write} = 3'b000;
    endtask

    task automatic run_program(input string name);
        int cycles;
        emit(enc_s(halt_addr, 0, 0));
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        cycles = 0;
        while (!halt_seen && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (!halt_seen) begin
            $display("%s: program never reached its halt store", name);
            test_errors++;
        end
    endtask

    task automatic check_word(input string name, input int idx, input logic [31:0] exp);
        if (mem[res_base + idx] !== exp) begin
            $display("ERROR %s word %0d: expected %h actual %h", name, idx, exp,
                     mem[res_base + idx]);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic test_reset();
        begin_test();
        emit(enc_i(5, 0, 0, 1, 7'h13));
        emit(enc_s(32'h200, 1, 0));
        run_program("reset");
        if (first_addr !== 32'h0 || first_write !== 1'b0) begin
            $display("reset: first transfer was not a read at address 0");
            test_errors++;
        end
        if (first_wr_addr !== 32'h200) begin
            $display("reset: a write happened before the first store instruction");
            test_errors++;
        end
        check_word("reset", 0, 32'd5);
        finish_test("reset");
    endtask

    task automatic test_alu(input string name, input logic stall);
        logic [31:0] a, b, sh, c;
        a  = -32'sd7;
        b  = 32'd3;
        sh = 32'd35;
        c  = 32'd2047;
        alu_exp = '{a + b, a - b, a & c, a | c, a ^ c, {31'b0, $signed(a) < $signed(b)},
                    {31'b0, $signed(b) < $signed(a)}, c << sh[4:0], a >> sh[4:0],
                    a - 32'd100, a & 32'hf0, a | 32'h100, ~a, {31'b0, $signed(a) < -8},
                    c << 4, a >> 28};
        stall_en = stall;
        begin_test();
        emit(enc_i(-7, 0, 0, 1, 7'h13));
        emit(enc_i(3, 0, 0, 2, 7'h13));
        emit(enc_i(35, 0, 0, 3, 7'h13));
        emit(enc_i(2047, 0, 0, 4, 7'h13));
        emit(enc_r(0, 2, 1, 0, 10));
        emit(enc_r(32, 2, 1, 0, 11));
        emit(enc_r(0, 4, 1, 7, 12));
        emit(enc_r(0, 4, 1, 6, 13));
        emit(enc_r(0, 4, 1, 4, 14));
        emit(enc_r(0, 2, 1, 2, 15));
        emit(enc_r(0, 1, 2, 2, 16));
        emit(enc_r(0, 3, 4, 1, 17));
        emit(enc_r(0, 3, 1, 5, 18));
        emit(enc_i(-100, 1, 0, 19, 7'h13));
        emit(enc_i(32'hf0, 1, 7, 20, 7'h13));
        emit(enc_i(32'h100, 1, 6, 21, 7'h13));
        emit(enc_i(-1, 1, 4, 22, 7'h13));
        emit(enc_i(-8, 1, 2, 23, 7'h13));
        emit(enc_i(4, 4, 1, 24, 7'h13));
        emit(enc_i(28, 1, 5, 25, 7'h13));
        for (int i = 0; i < 16; i++) emit(enc_s(32'h200 + 4 * i, 10 + i, 0));
        run_program(name);
        stall_en = 1'b0;
        for (int i = 0; i < 16; i++) begin
            check_word(name, i, alu_exp[i]);
            if (!stall) alu_first[i] = mem[res_base + i];
            else check_word(name, i, alu_first[i]);  // Same as the run without stalls.
        end
        finish_test(name);
    endtask

    task automatic test_load_store();
        begin_test();
        emit(enc_i(32'h123, 0, 0, 1, 7'h13));
        emit({20'habcde, 5'd2, 7'h37});
        emit(enc_s(32'h100, 1, 0));
        emit(enc_s(32'h104, 2, 0));
        emit(enc_i(32'h100, 0, 2, 3, 7'h03));
        emit(enc_i(32'h100, 0, 0, 5, 7'h13));
        emit(enc_i(4, 5, 2, 4, 7'h03));
        emit(enc_i(77, 0, 0, 0, 7'h13));  // Write to x0 is dropped.
        emit(enc_s(32'h200, 3, 0));
        emit(enc_s(32'h204, 4, 0));
        emit(enc_s(32'h208, 0, 0));
        run_program("load_store");
        check_word("load_store", 0, 32'h123);
        check_word("load_store", 1, 32'habcde000);
        check_word("load_store", 2, 32'h0);
        finish_test("load_store");
    endtask

    task automatic test_control_flow();
        int jal_pc;
        begin_test();
        emit(enc_i(1, 0, 0, 1, 7'h13));
        emit(enc_i(1, 0, 0, 2, 7'h13));
        for (int r = 10; r <= 15; r++) emit(enc_i(0, 0, 0, r, 7'h13));
        emit(enc_b(8, 2, 1, 0));           // beq taken.
        emit(enc_i(1, 0, 0, 10, 7'h13));
        emit(enc_b(8, 2, 1, 1));           // bne not taken.
        emit(enc_i(2, 0, 0, 11, 7'h13));
        emit(enc_b(8, 0, 1, 0));           // beq not taken.
        emit(enc_i(3, 0, 0, 12, 7'h13));
        emit(enc_b(8, 0, 1, 1));           // bne taken.
        emit(enc_i(4, 0, 0, 13, 7'h13));
        jal_pc = pi * 4;
        emit(enc_j(8, 14));
        emit(enc_i(5, 0, 0, 15, 7'h13));
        emit({20'h12345, 5'd16, 7'h37});
        for (int i = 0; i < 7; i++) emit(enc_s(32'h200 + 4 * i, 10 + i, 0));
        run_program("control_flow");
        check_word("control_flow", 0, 32'd0);
        check_word("control_flow", 1, 32'd2);
        check_word("control_flow", 2, 32'd3);
        check_word("control_flow", 3, 32'd0);
        check_word("control_flow", 4, jal_pc + 4);
        check_word("control_flow", 5, 32'd0);
        check_word("control_flow", 6, 32'h12345000);
        finish_test("control_flow");
    endtask

    initial begin
        tests_run = 0;
        tests_failed = 0;
        test_reset();
        test_alu("alu", 1'b0);
        test_load_store();
        test_control_flow();
        test_alu("alu_stalls", 1'b1);
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verification/core_props.sv */
`timescale 1ns/100ps

module core_props (
    input logic        clk,
    input logic        reset,
    input logic        mem_valid,
    input logic        mem_write,
    input logic [31:0] mem_addr,
    input logic [31:0] mem_wdata,
    input logic        mem_ready,
    input logic        done
);

    // Request held steady while the memory stalls.
    assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write) &&
        $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory request changed while waiting for ready");

    assert property (@(posedge clk) $fell(reset) |-> !mem_valid)
        else $error("mem_valid high in the first cycle after reset");

    // A read drops its request right after the handshake.
    assert property (@(posedge clk) disable iff (reset)
        done && !mem_write |=> !mem_valid)
        else $error("request still raised after a read handshake");

endmodule

bind mem_port core_props props0 (
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_write(mem_write),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
    .done(cmd.done)
);

/* source/rv_multicycle_top.sv */
`timescale 1ns/100ps

module rv_multicycle_top #(
    parameter core_pkg::word_t reset_pc  = '0,
    parameter int              reg_count = 32
) (
    input  logic            clk,
    input  logic            reset,
    output logic            mem_valid,
    output logic            mem_write,
    output core_pkg::word_t mem_addr,
    output core_pkg::word_t mem_wdata,
    input  logic            mem_ready,
    input  core_pkg::word_t mem_rdata
);

    core_pkg::decoded_t dec;
    core_pkg::src_a_t   src_a;
    core_pkg::src_b_t   src_b;
    core_pkg::alu_op_t  alu_op;
    core_pkg::wb_sel_t  wb_sel;
    core_pkg::word_t    pc, old_pc, instr, load_data;
    core_pkg::word_t    rs1_data, rs2_data;
    core_pkg::word_t    alu_result, alu_result_q;
    logic ir_write, pc_write, pc_cond, reg_write, zero;

    mem_cmd_if mem_cmd ();

    core_control control0 (
        .clk(clk), .reset(reset), .dec(dec), .mem(mem_cmd.control),
        .ir_write(ir_write), .pc_write(pc_write), .pc_cond(pc_cond),
        .src_a(src_a), .src_b(src_b), .alu_op(alu_op),
        .reg_write(reg_write), .wb_sel(wb_sel)
    );

    instr_decoder decoder0 (.instr(instr), .dec(dec));

    reg_file #(.reg_count(reg_count)) regs0 (
        .clk(clk), .dec(dec), .reg_write(reg_write), .wb_sel(wb_sel),
        .alu_result(alu_result_q), .load_data(load_data), .link_pc(old_pc),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu_unit alu0 (
        .clk(clk), .src_a(src_a), .src_b(src_b), .alu_op(alu_op),
        .pc(pc), .old_pc(old_pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm(dec.imm), .result(alu_result), .result_q(alu_result_q), .zero(zero)
    );

    mem_port #(.reset_pc(reset_pc)) port0 (
        .clk(clk), .reset(reset), .ir_write(ir_write), .pc_write(pc_write),
        .pc_cond(pc_cond), .zero(zero), .funct3_0(dec.funct3[0]),
        .alu_result(alu_result), .alu_result_q(alu_result_q), .rs2_data(rs2_data),
        .cmd(mem_cmd.port), .pc(pc), .old_pc(old_pc), .instr(instr),
        .load_data(load_data), .mem_valid(mem_valid), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

endmodule

/* source/mem_port.sv */
`timescale 1ns/100ps

module mem_port #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            ir_write,
    input  logic            pc_write,
    input  logic            pc_cond,
    input  logic            zero,
    input  logic            funct3_0,
    input  core_pkg::word_t alu_result,
    input  core_pkg::word_t alu_result_q,
    input  core_pkg::word_t rs2_data,
    mem_cmd_if.port         cmd,
    output core_pkg::word_t pc,
    output core_pkg::word_t old_pc,
    output core_pkg::word_t instr,
    output core_pkg::word_t load_data,
    output logic            mem_valid,
    output logic            mem_write,
    output core_pkg::word_t mem_addr,
    output core_pkg::word_t mem_wdata,
    input  logic            mem_ready,
    input  core_pkg::word_t mem_rdata
);

    logic active;
    logic handshake;
    logic take_pc;

    // Holds the bus idle for the first cycle out of reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    assign mem_valid = cmd.req & active;
    assign mem_write = cmd.write & mem_valid;
    assign mem_addr  = cmd.data_addr ? alu_result_q : pc;
    assign mem_wdata = rs2_data;

    assign handshake = mem_valid & mem_ready;
    assign cmd.done  = handshake;

    // beq on zero, bne on not zero.
    assign take_pc = pc_write | (pc_cond & (zero ^ funct3_0));

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= reset_pc;
            old_pc <= reset_pc;
        end else if (take_pc) begin
            old_pc <= pc;  // Instruction address after fetch, link after jal.
            pc     <= ir_write ? alu_result : alu_result_q;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write) begin
            instr <= mem_rdata;
        end
        if (handshake && cmd.data_addr && !cmd.write) begin
            load_data <= mem_rdata;
        end
    end

endmodule

/* source/alu_unit.sv */
`timescale 1ns/100ps

module alu_unit (
    input  logic              clk,
    input  core_pkg::src_a_t  src_a,
    input  core_pkg::src_b_t  src_b,
    input  core_pkg::alu_op_t alu_op,
    input  core_pkg::word_t   pc,
    input  core_pkg::word_t   old_pc,
    input  core_pkg::word_t   rs1_data,
    input  core_pkg::word_t   rs2_data,
    input  core_pkg::word_t   imm,
    output core_pkg::word_t   result,
    output core_pkg::word_t   result_q,
    output logic              zero
);

    core_pkg::word_t a;
    core_pkg::word_t b;
    logic less;

    always_comb begin
        case (src_a)
            core_pkg::src_a_pc:     a = pc;
            core_pkg::src_a_old_pc: a = old_pc;
            core_pkg::src_a_rs1:    a = rs1_data;
            default:                a = '0;
        endcase
        case (src_b)
            core_pkg::src_b_imm:  b = imm;
            core_pkg::src_b_four: b = core_pkg::word_t'(4);
            default:              b = rs2_data;
        endcase
    end

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (alu_op)
            core_pkg::alu_sub: result = a - b;
            core_pkg::alu_and: result = a & b;
            core_pkg::alu_or:  result = a | b;
            core_pkg::alu_xor: result = a ^ b;
            core_pkg::alu_slt: result = {{(core_pkg::xlen - 1){1'b0}}, less};
            core_pkg::alu_sll: result = a << b[4:0];
            core_pkg::alu_srl: result = a >> b[4:0];
            default:           result = a + b;
        endcase
    end

    assign zero = (result == '0);  // Branch compare.

    always_ff @(posedge clk) begin
        result_q <= result;
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
    parameter int reg_count = 32
) (
    input  logic               clk,
    input  core_pkg::decoded_t dec,
    input  logic               reg_write,
    input  core_pkg::wb_sel_t  wb_sel,
    input  core_pkg::word_t    alu_result,
    input  core_pkg::word_t    load_data,
    input  core_pkg::word_t    link_pc,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data
);

    localparam int idx_w = $clog2(reg_count);  // Upper bit dropped for RV32E.

    core_pkg::word_t regs [reg_count];
    core_pkg::word_t wdata;
    logic [idx_w-1:0] rs1_idx;
    logic [idx_w-1:0] rs2_idx;
    logic [idx_w-1:0] rd_idx;

    assign rs1_idx = dec.rs1[idx_w-1:0];
    assign rs2_idx = dec.rs2[idx_w-1:0];
    assign rd_idx  = dec.rd[idx_w-1:0];

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_comb begin
        case (wb_sel)
            core_pkg::wb_load: wdata = load_data;
            core_pkg::wb_link: wdata = link_pc;
            default:           wdata = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_write && rd_idx != '0) begin
            regs[rd_idx] <= wdata;
        end
    end

endmodule

/* source/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder (
    input  core_pkg::word_t    instr,
    output core_pkg::decoded_t dec
);

    core_pkg::word_t imm_i;
    core_pkg::word_t imm_s;
    core_pkg::word_t imm_b;
    core_pkg::word_t imm_j;
    core_pkg::word_t imm_u;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec.opcode     = core_pkg::opcode_t'(instr[6:0]);
        dec.rd         = instr[11:7];
        dec.rs1        = instr[19:15];
        dec.rs2        = instr[24:20];
        dec.funct3     = instr[14:12];
        dec.funct7_bit = instr[30];
        case (dec.opcode)
            core_pkg::op_store:  dec.imm = imm_s;
            core_pkg::op_branch: dec.imm = imm_b;
            core_pkg::op_jal:    dec.imm = imm_j;
            core_pkg::op_lui:    dec.imm = imm_u;
            default:             dec.imm = imm_i;  // Loads and I-type.
        endcase
    end

endmodule

/* source/core_control.sv */
`timescale 1ns/100ps

module core_control (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::decoded_t  dec,
    mem_cmd_if.control          mem,
    output logic                ir_write,
    output logic                pc_write,
    output logic                pc_cond,
    output core_pkg::src_a_t    src_a,
    output core_pkg::src_b_t    src_b,
    output core_pkg::alu_op_t   alu_op,
    output logic                reg_write,
    output core_pkg::wb_sel_t   wb_sel
);

    typedef enum logic [3:0] {
        fetch,
        decode,
        mem_addr,
        mem_read,
        mem_wb,
        mem_write,
        exec_r,
        exec_i,
        alu_wb,
        jal_st,
        branch_st,
        lui_st
    } state_t;

    state_t state, next_state;
    core_pkg::alu_op_t func_op;
    logic mem_op;

    assign mem_op = (dec.opcode == core_pkg::op_load) || (dec.opcode == core_pkg::op_store);

    // funct3 to ALU operation. Bit 30 picks sub for R-type only.
    always_comb begin
        case (dec.funct3)
            3'b000: begin
                if (dec.opcode == core_pkg::op_rtype && dec.funct7_bit) begin
                    func_op = core_pkg::alu_sub;
                end else begin
                    func_op = core_pkg::alu_add;
                end
            end
            3'b001: func_op = core_pkg::alu_sll;
            3'b010: func_op = core_pkg::alu_slt;
            3'b100: func_op = core_pkg::alu_xor;
            3'b101: func_op = core_pkg::alu_srl;
            3'b110: func_op = core_pkg::alu_or;
            3'b111: func_op = core_pkg::alu_and;
            default: func_op = core_pkg::alu_add;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = fetch;
        case (state)
            fetch:     next_state = mem.done ? decode : fetch;
            decode: begin
                case (dec.opcode)
                    core_pkg::op_load:   next_state = mem_addr;
                    core_pkg::op_store:  next_state = mem_write;  // Address formed in decode.
                    core_pkg::op_rtype:  next_state = exec_r;
                    core_pkg::op_itype:  next_state = exec_i;
                    core_pkg::op_jal:    next_state = jal_st;
                    core_pkg::op_branch: next_state = branch_st;
                    core_pkg::op_lui:    next_state = lui_st;
                    default:             next_state = fetch;
                endcase
            end
            mem_addr:  next_state = (dec.opcode == core_pkg::op_load) ? mem_read : mem_write;
            mem_read:  next_state = mem.done ? mem_wb : mem_read;
            mem_write: next_state = mem.done ? fetch : mem_write;
            exec_r, exec_i, jal_st, lui_st: next_state = alu_wb;
            default:   next_state = fetch;
        endcase
    end

    always_comb begin
        ir_write      = 1'b0;
        pc_write      = 1'b0;
        pc_cond       = 1'b0;
        src_a         = core_pkg::src_a_pc;
        src_b         = core_pkg::src_b_four;
        alu_op        = core_pkg::alu_add;
        reg_write     = 1'b0;
        wb_sel        = core_pkg::wb_alu;
        mem.req       = 1'b0;
        mem.write     = 1'b0;
        mem.data_addr = 1'b0;
        case (state)
            fetch: begin
                mem.req  = 1'b1;
                ir_write = mem.done;
                pc_write = mem.done;  // PC takes pc plus four.
            end
            decode: begin
                // Data address for memory ops, branch or jump target otherwise.
                src_a = mem_op ? core_pkg::src_a_rs1 : core_pkg::src_a_old_pc;
                src_b = core_pkg::src_b_imm;
            end
            mem_addr: begin
                src_a = core_pkg::src_a_rs1;
                src_b = core_pkg::src_b_imm;
            end
            mem_read: begin
                mem.req       = 1'b1;
                mem.data_addr = 1'b1;
                src_a         = core_pkg::src_a_rs1;  // Keeps the address steady.
                src_b         = core_pkg::src_b_imm;
            end
            mem_wb: begin
                reg_write = 1'b1;
                wb_sel    = core_pkg::wb_load;
            end
            mem_write: begin
                mem.req       = 1'b1;
                mem.write     = 1'b1;
                mem.data_addr = 1'b1;
                src_a         = core_pkg::src_a_rs1;
                src_b         = core_pkg::src_b_imm;
            end
            exec_r: begin
                src_a  = core_pkg::src_a_rs1;
                src_b  = core_pkg::src_b_rs2;
                alu_op = func_op;
            end
            exec_i: begin
                src_a  = core_pkg::src_a_rs1;
                src_b  = core_pkg::src_b_imm;
                alu_op = func_op;
            end
            alu_wb: begin
                reg_write = 1'b1;
                if (dec.opcode == core_pkg::op_jal) begin
                    wb_sel = core_pkg::wb_link;
                end
            end
            jal_st: pc_write = 1'b1;
            branch_st: begin
                src_a   = core_pkg::src_a_rs1;
                src_b   = core_pkg::src_b_rs2;
                alu_op  = core_pkg::alu_sub;
                pc_cond = 1'b1;
            end
            lui_st: begin
                src_a = core_pkg::src_a_zero;
                src_b = core_pkg::src_b_imm;
            end
            default: ;
        endcase
    end

endmodule

/* source/mem_cmd_if.sv */
`timescale 1ns/100ps

interface mem_cmd_if;

    logic req;        // Held until done.
    logic write;
    logic data_addr;  // Address from the ALU result register.
    logic done;       // One cycle, on the handshake.

    modport control (
        output req,
        output write,
        output data_addr,
        input  done
    );

    modport port (
        input  req,
        input  write,
        input  data_addr,
        output done
    );

endinterface

/* source/core_pkg.sv */
package core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_rtype  = 7'b0110011,
        op_itype  = 7'b0010011,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        src_a_pc     = 2'd0,
        src_a_old_pc = 2'd1,
        src_a_rs1    = 2'd2,
        src_a_zero   = 2'd3
    } src_a_t;

    typedef enum logic [1:0] {
        src_b_rs2  = 2'd0,
        src_b_imm  = 2'd1,
        src_b_four = 2'd2
    } src_b_t;

    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_load = 2'd1,
        wb_link = 2'd2
    } wb_sel_t;

    // Instruction fields after decode.
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [2:0] funct3;
        logic      funct7_bit;  // Instruction bit 30.
        word_t     imm;
    } decoded_t;

endpackage
